// File: logic/frameParser.sv
`timescale 1ns/1ps

module frameParser import tcpTapPkg::*; (
	input  logic         CLOCK,
	input  logic         reset,
	input  logic         newPacket,
	input  logic         dataValid,
	input  byte_t        data,
	output headerField_t fieldSel,
	output logic [1:0]   fieldIndex,
	output logic         byteAccept,
	output seqNum_t      seqNumber,
	output logic         synFlag,
	output logic         flagsDone,
	output logic         payloadAccept,
	output byte_t        outData,
	output logic         outPayload,
	output logic         outNewPacket,
	output ipAddr_t      srcIp,
	output ipAddr_t      dstIp,
	output tcpPort_t     srcPort,
	output tcpPort_t     dstPort
);

	parseState_t state;
	logic [4:0]  byteCount;     // position inside a counted state or option word
	logic [3:0]  ipWords;       // ihl, counted down over option words
	logic [3:0]  tcpWords;      // data offset, likewise
	logic [15:0] ipLength;      // total length, later ip payload length
	logic [15:0] payloadCount;
	byte_t       typeHi;
	logic        synHeld;
	logic        headerDone;

	////////////////////////////////////////////////////////////////////
	// strobes towards matchers and trackers
	////////////////////////////////////////////////////////////////////

	assign byteAccept    = dataValid && !(state inside {IDLE, PAYLOAD, SKIP});
	assign payloadAccept = dataValid && (state == PAYLOAD);
	assign flagsDone     = byteAccept && (state == TCP_FIXED) && (byteCount == 5'd13);
	assign synFlag       = flagsDone ? data[1] : synHeld;   // live on the flags byte

	// last byte of the tcp header, with or without options
	assign headerDone = byteAccept && (
		(state == TCP_FIXED && byteCount == FIXED_HEADER_BYTES - 5'd1 &&
			tcpWords <= MIN_HEADER_WORDS) ||
		(state == TCP_OPTIONS && byteCount == 5'd3 &&
			tcpWords == MIN_HEADER_WORDS + 4'd1));

	always_comb begin
		fieldSel   = FIELD_NONE;
		fieldIndex = byteCount[1:0];
		if (state == IP_FIXED) begin
			if (byteCount >= 5'd12 && byteCount <= 5'd15) begin
				fieldSel = FIELD_SRC_IP;
			end else if (byteCount >= 5'd16) begin
				fieldSel = FIELD_DST_IP;
			end
		end else if (state == TCP_FIXED) begin
			fieldIndex = {1'b0, byteCount[0]};  // ports are two bytes
			if (byteCount <= 5'd1) begin
				fieldSel = FIELD_SRC_PORT;
			end else if (byteCount <= 5'd3) begin
				fieldSel = FIELD_DST_PORT;
			end
		end
	end

	////////////////////////////////////////////////////////////////////
	// header walk
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK) begin
		if (reset) begin
			state        <= IDLE;
			byteCount    <= '0;
			ipWords      <= '0;
			tcpWords     <= '0;
			ipLength     <= '0;
			payloadCount <= '0;
			synHeld      <= 1'b0;
		end else if (newPacket) begin
			state     <= ETH_MAC;   // restart wherever we were
			byteCount <= '0;
		end else if (dataValid) begin
			byteCount <= byteCount + 5'd1;
			case (state)
				ETH_MAC: begin
					if (byteCount == ETH_MAC_BYTES - 5'd1) begin
						state <= ETH_TYPE_HI;
					end
				end
				ETH_TYPE_HI: begin
					state <= ETH_TYPE_LO;
				end
				ETH_TYPE_LO: begin
					byteCount <= '0;
					if ({typeHi, data} == ETH_TYPE_VLAN) begin
						state <= VLAN_TAG;
					end else if ({typeHi, data} == ETH_TYPE_IPV4) begin
						state <= IP_FIXED;
					end else begin
						state <= SKIP;
					end
				end
				VLAN_TAG: begin
					// back to the ethertype, tags may stack
					if (byteCount == VLAN_TAG_BYTES - 5'd1) begin
						state <= ETH_TYPE_HI;
					end
				end
				IP_FIXED: begin
					case (byteCount)
						5'd0: ipWords <= data[3:0];
						5'd2: ipLength[15:8] <= data;
						5'd3: ipLength[7:0] <= data;
						5'd9: begin
							if (data != IP_PROTO_TCP) begin
								state <= SKIP;
							end
						end
						5'd19: begin
							ipLength  <= ipLength - {10'd0, ipWords, 2'b00};
							byteCount <= '0;
							state <= (ipWords > MIN_HEADER_WORDS) ? IP_OPTIONS : TCP_FIXED;
						end
						default: ;
					endcase
				end
				IP_OPTIONS: begin
					if (byteCount == 5'd3) begin
						byteCount <= '0;
						ipWords   <= ipWords - 4'd1;
						if (ipWords == MIN_HEADER_WORDS + 4'd1) begin
							state <= TCP_FIXED;
						end
					end
				end
				TCP_FIXED: begin
					case (byteCount)
						5'd12: begin
							// both header lengths known here
							tcpWords     <= data[7:4];
							payloadCount <= ipLength - {10'd0, data[7:4], 2'b00};
						end
						5'd13: synHeld <= data[1];
						5'd19: begin
							byteCount <= '0;
							if (tcpWords > MIN_HEADER_WORDS) begin
								state <= TCP_OPTIONS;
							end else begin
								state <= (payloadCount != 0) ? PAYLOAD : IDLE;
							end
						end
						default: ;
					endcase
				end
				TCP_OPTIONS: begin
					if (byteCount == 5'd3) begin
						byteCount <= '0;
						tcpWords  <= tcpWords - 4'd1;
						if (tcpWords == MIN_HEADER_WORDS + 4'd1) begin
							state <= (payloadCount != 0) ? PAYLOAD : IDLE;
						end
					end
				end
				PAYLOAD: begin
					payloadCount <= payloadCount - 16'd1;
					if (payloadCount == 16'd1) begin
						state <= IDLE;
					end
				end
				default: byteCount <= '0;   // idle and skip just wait
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////
	// field capture and payload stream
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK) begin
		if (byteAccept) begin
			if (state == ETH_TYPE_HI) begin
				typeHi <= data;
			end
			if (state == TCP_FIXED && byteCount >= 5'd4 && byteCount <= 5'd7) begin
				seqNumber[8 * (7 - byteCount) +: 8] <= data;   // msb first
			end
			case (fieldSel)
				FIELD_SRC_IP:   srcIp[8 * (3 - fieldIndex) +: 8] <= data;
				FIELD_DST_IP:   dstIp[8 * (3 - fieldIndex) +: 8] <= data;
				FIELD_SRC_PORT: srcPort[8 * (1 - fieldIndex[0]) +: 8] <= data;
				FIELD_DST_PORT: dstPort[8 * (1 - fieldIndex[0]) +: 8] <= data;
				default: ;
			endcase
		end
		if (payloadAccept) begin
			outData <= data;
		end
	end

	always_ff @(posedge CLOCK) begin
		if (reset) begin
			outPayload   <= 1'b0;
			outNewPacket <= 1'b0;
		end else begin
			outPayload   <= payloadAccept;
			outNewPacket <= headerDone && (payloadCount != 0);  // no pulse for empty segments
		end
	end

endmodule

// File: logic/sequenceTracker.sv
`timescale 1ns/1ps

module sequenceTracker import tcpTapPkg::*; (
	input  logic    CLOCK,
	input  logic    reset,
	input  logic    sessionHit,
	input  logic    flagsDone,
	input  seqNum_t seqNumber,
	input  logic    synFlag,
	input  logic    payloadAccept,
	input  logic    outPayloadIn,
	output logic    gapped,
	output logic    outMatch
);

	seqNum_t expectedSeq;   // next byte we expect on this session
	logic    hitDelayed;

	////////////////////////////////////////////////////////////////////
	// expected sequence and gap flag
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK) begin
		if (reset) begin
			expectedSeq <= '0;
			gapped      <= 1'b0;
		end else if (flagsDone && sessionHit) begin
			if (synFlag) begin
				// syn takes one sequence number
				expectedSeq <= seqNumber + 32'd1;
				gapped      <= 1'b0;
			end else begin
				gapped      <= (seqNumber != expectedSeq);
				expectedSeq <= seqNumber;   // resync after a gap
			end
		end else if (payloadAccept && sessionHit) begin
			expectedSeq <= expectedSeq + 32'd1;   // one per payload byte
		end
	end

	////////////////////////////////////////////////////////////////////
	// matched payload strobe
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLOCK) begin
		if (reset) begin
			hitDelayed <= 1'b0;
		end else begin
			hitDelayed <= sessionHit;
		end
	end

	// hit as it stood when the payload byte was accepted
	assign outMatch = hitDelayed && outPayloadIn;

endmodule

// File: logic/sessionMatcher.sv
`timescale 1ns/1ps

module sessionMatcher import tcpTapPkg::*; (
	input  logic         CLOCK,
	input  logic         reset,
	input  logic         newPacket,
	input  logic         byteAccept,
	input  headerField_t fieldSel,
	input  logic [1:0]   fieldIndex,
	input  byte_t        data,
	input  ipAddr_t      expSrcIp,
	input  ipAddr_t      expDstIp,
	input  tcpPort_t     expSrcPort,
	input  tcpPort_t     expDstPort,
	output logic         sessionHit
);

	logic  mismatch;
	logic  tupleSeen;   // last dst port byte went past
	logic  fieldByte;
	byte_t expectedByte;

	assign fieldByte = byteAccept && (fieldSel != FIELD_NONE);

	// byte of the programmed tuple lined up with the bus
	always_comb begin
		case (fieldSel)
			FIELD_SRC_IP:   expectedByte = expSrcIp[8 * (3 - fieldIndex) +: 8];
			FIELD_DST_IP:   expectedByte = expDstIp[8 * (3 - fieldIndex) +: 8];
			FIELD_SRC_PORT: expectedByte = expSrcPort[8 * (1 - fieldIndex[0]) +: 8];
			FIELD_DST_PORT: expectedByte = expDstPort[8 * (1 - fieldIndex[0]) +: 8];
			default:        expectedByte = data;
		endcase
	end

	always_ff @(posedge CLOCK) begin
		if (reset || newPacket) begin
			mismatch  <= 1'b0;
			tupleSeen <= 1'b0;
		end else if (fieldByte) begin
			if (data != expectedByte) begin
				mismatch <= 1'b1;   // sticky for the rest of the frame
			end
			if (fieldSel == FIELD_DST_PORT && fieldIndex[0]) begin
				tupleSeen <= 1'b1;
			end
		end
	end

	assign sessionHit = tupleSeen && !mismatch;

endmodule

// File: logic/tcpStreamTap.sv
`timescale 1ns/1ps

module tcpStreamTap import tcpTapPkg::*; #(
	parameter int NUM_SESSIONS = 4
) (
	input  logic                        CLOCK,
	input  logic                        reset,
	input  logic                        newPacket,
	input  logic                        dataValid,
	input  byte_t                       data,
	input  ipAddr_t  [NUM_SESSIONS-1:0] sessionSrcIp,
	input  ipAddr_t  [NUM_SESSIONS-1:0] sessionDstIp,
	input  tcpPort_t [NUM_SESSIONS-1:0] sessionSrcPort,
	input  tcpPort_t [NUM_SESSIONS-1:0] sessionDstPort,
	output byte_t                       outData,
	output logic                        outPayload,
	output logic                        outNewPacket,
	output logic     [NUM_SESSIONS-1:0] outMatch,
	output logic     [NUM_SESSIONS-1:0] headerMatch,
	output logic     [NUM_SESSIONS-1:0] gapped,
	output ipAddr_t                     srcIp,
	output ipAddr_t                     dstIp,
	output tcpPort_t                    srcPort,
	output tcpPort_t                    dstPort
);

	headerField_t fieldSel;
	logic [1:0]   fieldIndex;
	logic         byteAccept;
	seqNum_t      seqNumber;
	logic         synFlag;
	logic         flagsDone;
	logic         payloadAccept;

	// one header walker shared by all sessions
	frameParser parser (
		.CLOCK         (CLOCK),
		.reset         (reset),
		.newPacket     (newPacket),
		.dataValid     (dataValid),
		.data          (data),
		.fieldSel      (fieldSel),
		.fieldIndex    (fieldIndex),
		.byteAccept    (byteAccept),
		.seqNumber     (seqNumber),
		.synFlag       (synFlag),
		.flagsDone     (flagsDone),
		.payloadAccept (payloadAccept),
		.outData       (outData),
		.outPayload    (outPayload),
		.outNewPacket  (outNewPacket),
		.srcIp         (srcIp),
		.dstIp         (dstIp),
		.srcPort       (srcPort),
		.dstPort       (dstPort)
	);

	////////////////////////////////////////////////////////////////////
	// per session match and sequence tracking
	////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < NUM_SESSIONS; i++) begin : gSession
		sessionMatcher matcher (
			.CLOCK      (CLOCK),
			.reset      (reset),
			.newPacket  (newPacket),
			.byteAccept (byteAccept),
			.fieldSel   (fieldSel),
			.fieldIndex (fieldIndex),
			.data       (data),
			.expSrcIp   (sessionSrcIp[i]),
			.expDstIp   (sessionDstIp[i]),
			.expSrcPort (sessionSrcPort[i]),
			.expDstPort (sessionDstPort[i]),
			.sessionHit (headerMatch[i])
		);

		sequenceTracker tracker (
			.CLOCK         (CLOCK),
			.reset         (reset),
			.sessionHit    (headerMatch[i]),
			.flagsDone     (flagsDone),
			.seqNumber     (seqNumber),
			.synFlag       (synFlag),
			.payloadAccept (payloadAccept),
			.outPayloadIn  (outPayload),
			.gapped        (gapped[i]),
			.outMatch      (outMatch[i])
		);
	end

endmodule

// File: logic/tcpTapPkg.sv
package tcpTapPkg;

	////////////////////////////////////////////////////////////////////
	// bus and header field types
	////////////////////////////////////////////////////////////////////

	typedef logic [7:0]  byte_t;
	typedef logic [31:0] ipAddr_t;
	typedef logic [15:0] tcpPort_t;
	typedef logic [31:0] seqNum_t;

	// ethertypes and ip protocol numbers
	localparam logic [15:0] ETH_TYPE_VLAN = 16'h8100;   // 802.1Q tag follows
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
	localparam logic [7:0]  IP_PROTO_TCP  = 8'd6;

	// ihl and data offset without options, in 32-bit words
	localparam logic [3:0] MIN_HEADER_WORDS = 4'd5;

	// byte lengths of the counted header states
	localparam logic [4:0] ETH_MAC_BYTES      = 5'd12;  // dst + src mac
	localparam logic [4:0] VLAN_TAG_BYTES     = 5'd2;   // tci only, tpid already seen
	localparam logic [4:0] FIXED_HEADER_BYTES = 5'd20;  // ipv4 and tcp alike

	////////////////////////////////////////////////////////////////////
	// parser states and tuple field select
	////////////////////////////////////////////////////////////////////

	typedef enum logic [3:0] {
		IDLE,
		ETH_MAC,
		ETH_TYPE_HI,
		ETH_TYPE_LO,
		VLAN_TAG,
		IP_FIXED,
		IP_OPTIONS,
		TCP_FIXED,
		TCP_OPTIONS,
		PAYLOAD,
		SKIP        // rest of frame ignored until newPacket
	} parseState_t;

	typedef enum logic [2:0] {
		FIELD_NONE,
		FIELD_SRC_IP,
		FIELD_DST_IP,
		FIELD_SRC_PORT,
		FIELD_DST_PORT
	} headerField_t;

endpackage

// File: runSim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tcpStreamTapTb \
	-f tcpStreamTap.f -o tcpStreamTapSim

./obj_dir/tcpStreamTapSim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "TB PASSED" sim.log; then
	echo "simulation ended without a result line"
	exit 1
fi
exit 0

// File: tcpStreamTap.f
+incdir+testbench
logic/tcpTapPkg.sv
logic/frameParser.sv
logic/sessionMatcher.sv
logic/sequenceTracker.sv
logic/tcpStreamTap.sv
testbench/tcpStreamTapTb.sv

// File: testbench/frameBuilder.svh
`ifndef FRAME_BUILDER_SVH
`define FRAME_BUILDER_SVH

// 32-bit linear congruential generator, one byte per call
function automatic logic [7:0] nextRandom();
	lcgState = lcgState * 32'd1103515245 + 32'd12345;
	return lcgState[23:16];
endfunction

// network order, most significant byte first
task automatic pushBytes(input logic [31:0] value, input int count);
	for (int k = count - 1; k >= 0; k--) begin
		frameBytes.push_back(value[8 * k +: 8]);
	end
endtask

////////////////////////////////////////////////////////////////////////
// one table row into wire bytes plus the payload expected back
////////////////////////////////////////////////////////////////////////

task automatic buildFrame(input row_t r);
	logic [3:0]  ipWords;
	logic [3:0]  tcpWords;
	logic [15:0] totalLength;
	logic [7:0]  payloadByte;
	logic        isTcp;
	frameBytes.delete();
	expPayload.delete();
	ipWords     = 4'(5 + r.ipOptWords);
	tcpWords    = 4'(5 + r.tcpOptWords);
	totalLength = 16'(4 * (10 + r.ipOptWords + r.tcpOptWords) + r.payloadLen);
	isTcp       = (r.etherType == 16'h0800) && (r.protocol == 8'd6);
	for (int k = 0; k < 12; k++) begin
		frameBytes.push_back(nextRandom());   // dst and src mac
	end
	for (int k = 0; k < r.vlanTags; k++) begin
		pushBytes(32'h0000_8100, 2);
		pushBytes(32'(k + 1), 2);   // tci carries the vlan id
	end
	pushBytes({16'd0, r.etherType}, 2);
	// ipv4 header, checksum left at zero
	pushBytes({4'h4, ipWords, 8'h00, totalLength}, 4);
	pushBytes(32'h1234_4000, 4);
	pushBytes({8'd64, r.protocol, 16'h0000}, 4);
	pushBytes(r.srcIp, 4);
	pushBytes(r.dstIp, 4);
	for (int k = 0; k < r.ipOptWords; k++) begin
		pushBytes(32'h0101_0101, 4);   // nop options
	end
	// tcp header
	pushBytes({r.srcPort, r.dstPort}, 4);
	pushBytes(r.seq, 4);
	pushBytes(32'd0, 4);   // ack number
	pushBytes({tcpWords, 4'h0, (r.syn ? 8'h02 : 8'h18), 16'hffff}, 4);
	pushBytes(32'd0, 4);
	for (int k = 0; k < r.tcpOptWords; k++) begin
		pushBytes(32'h0101_0101, 4);
	end
	for (int k = 0; k < r.payloadLen; k++) begin
		payloadByte = nextRandom();
		frameBytes.push_back(payloadByte);
		if (isTcp) begin
			expPayload.push_back(payloadByte);
		end
	end
endtask

`endif

// File: testbench/tcpStreamTapTb.sv
`timescale 1ns/1ps

module tcpStreamTapTb;

	localparam int NUM_SESSIONS = 4;

	typedef struct packed {
		int          vlanTags;
		logic [15:0] etherType;
		logic [7:0]  protocol;
		int          ipOptWords;
		int          tcpOptWords;
		logic [31:0] srcIp;
		logic [31:0] dstIp;
		logic [15:0] srcPort;
		logic [15:0] dstPort;
		logic [31:0] seq;
		logic        syn;
		int          payloadLen;
		int          session;   // -1 when no session should hit
		logic        gapped;
	} row_t;

	logic                          CLOCK = 1'b0;
	logic                          reset;
	logic                          newPacket;
	logic                          dataValid;
	logic [7:0]                    data;
	logic [NUM_SESSIONS-1:0][31:0] sessionSrcIp;
	logic [NUM_SESSIONS-1:0][31:0] sessionDstIp;
	logic [NUM_SESSIONS-1:0][15:0] sessionSrcPort;
	logic [NUM_SESSIONS-1:0][15:0] sessionDstPort;
	logic [7:0]                    outData;
	logic                          outPayload;
	logic                          outNewPacket;
	logic [NUM_SESSIONS-1:0]       outMatch;
	logic [NUM_SESSIONS-1:0]       headerMatch;
	logic [NUM_SESSIONS-1:0]       gapped;
	logic [31:0]                   srcIp;
	logic [31:0]                   dstIp;
	logic [15:0]                   srcPort;
	logic [15:0]                   dstPort;

	logic [31:0]             lcgState = 32'd46088;
	logic [7:0]              frameBytes[$];
	logic [7:0]              expPayload[$];
	row_t                    rows[$];
	string                   names[$];
	string                   testName;
	int                      errorCount;
	int                      checkCount;
	int                      payloadSeen;
	int                      newPacketSeen;
	int                      watchdogCycles;
	logic                    payloadDue;   // payload byte on the bus this cycle
	logic [31:0]             matchMask;
	logic [31:0]             modelSeq[NUM_SESSIONS];   // reference expected sequence
	logic [NUM_SESSIONS-1:0] modelGap;

	`include "frameBuilder.svh"

	tcpStreamTap #(.NUM_SESSIONS(NUM_SESSIONS)) DUT (
		.CLOCK(CLOCK), .reset(reset), .newPacket(newPacket), .dataValid(dataValid),
		.data(data), .sessionSrcIp(sessionSrcIp), .sessionDstIp(sessionDstIp),
		.sessionSrcPort(sessionSrcPort), .sessionDstPort(sessionDstPort),
		.outData(outData), .outPayload(outPayload), .outNewPacket(outNewPacket),
		.outMatch(outMatch), .headerMatch(headerMatch), .gapped(gapped),
		.srcIp(srcIp), .dstIp(dstIp), .srcPort(srcPort), .dstPort(dstPort)
	);

	initial begin
		forever #5 CLOCK = ~CLOCK;
	end

	task automatic checkValue(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("[ERROR] %s %s: expected %0h, actual %0h", testName, what, expected, actual);
		end
	endtask

	task automatic addRow(input string name, input int tags, input logic [15:0] etype,
			input logic [7:0] proto, input int ipOpt, input int tcpOpt,
			input logic [31:0] sIp, input logic [31:0] dIp, input logic [15:0] sPort,
			input logic [15:0] dPort, input logic [31:0] seqIn, input logic synIn,
			input int length, input int sessionIn, input logic gapIn);
		row_t r;
		r = '{tags, etype, proto, ipOpt, tcpOpt, sIp, dIp, sPort, dPort, seqIn, synIn,
			length, sessionIn, gapIn};
		names.push_back(name);
		rows.push_back(r);
	endtask

	////////////////////////////////////////////////////////////////////////
	// stimulus table against sessions 0 to 3 programmed below
	////////////////////////////////////////////////////////////////////////

	task automatic fillTable();
		addRow("syn opens s0", 0, 16'h0800, 8'd6, 0, 0, 32'h0a000001, 32'h0a000002,
			16'd1000, 16'd80, 32'd1000, 1'b1, 0, 0, 1'b0);
		addRow("plain s0", 0, 16'h0800, 8'd6, 0, 0, 32'h0a000001, 32'h0a000002,
			16'd1000, 16'd80, 32'd1001, 1'b0, 16, 0, 1'b0);
		addRow("vlan s0", 1, 16'h0800, 8'd6, 0, 0, 32'h0a000001, 32'h0a000002,
			16'd1000, 16'd80, 32'd1017, 1'b0, 5, 0, 1'b0);
		addRow("stacked s0", 2, 16'h0800, 8'd6, 2, 3, 32'h0a000001, 32'h0a000002,
			16'd1000, 16'd80, 32'd1022, 1'b0, 9, 0, 1'b0);
		addRow("skipped seq s0", 0, 16'h0800, 8'd6, 0, 0, 32'h0a000001, 32'h0a000002,
			16'd1000, 16'd80, 32'd1100, 1'b0, 4, 0, 1'b1);
		addRow("resync s0", 0, 16'h0800, 8'd6, 0, 0, 32'h0a000001, 32'h0a000002,
			16'd1000, 16'd80, 32'd1104, 1'b0, 7, 0, 1'b0);
		addRow("syn s1", 1, 16'h0800, 8'd6, 0, 0, 32'hc0a80105, 32'hc0a80109,
			16'd5000, 16'd443, 32'h7fffffff, 1'b1, 0, 1, 1'b0);
		addRow("options s1", 0, 16'h0800, 8'd6, 1, 1, 32'hc0a80105, 32'hc0a80109,
			16'd5000, 16'd443, 32'h80000000, 1'b0, 12, 1, 1'b0);
		addRow("empty ack s1", 0, 16'h0800, 8'd6, 0, 0, 32'hc0a80105, 32'hc0a80109,
			16'd5000, 16'd443, 32'h8000000c, 1'b0, 0, 1, 1'b0);
		addRow("first data s2", 3, 16'h0800, 8'd6, 0, 0, 32'hac100001, 32'hac100002,
			16'd22, 16'd2222, 32'd500, 1'b0, 3, 2, 1'b1);   // nothing expected yet
		addRow("ip options s3", 0, 16'h0800, 8'd6, 4, 0, 32'h0a000003, 32'h0a000004,
			16'd1234, 16'd5678, 32'd0, 1'b0, 20, 3, 1'b0);
		addRow("arp ethertype", 0, 16'h0806, 8'd6, 0, 0, 32'h0a000001, 32'h0a000002,
			16'd1000, 16'd80, 32'd1111, 1'b0, 8, -1, 1'b0);
		addRow("udp protocol", 0, 16'h0800, 8'd17, 0, 0, 32'h0a000001, 32'h0a000002,
			16'd1000, 16'd80, 32'd1111, 1'b0, 8, -1, 1'b0);
		addRow("near miss port", 0, 16'h0800, 8'd6, 0, 0, 32'h0a000001, 32'h0a000002,
			16'd1000, 16'd81, 32'd1111, 1'b0, 6, -1, 1'b0);
	endtask

	// called on every falling edge before new inputs go out
	task automatic samplePorts();
		checkValue("outPayload", 32'(payloadDue), 32'(outPayload));
		if (outNewPacket) begin
			newPacketSeen++;
			checkValue("outNewPacket ahead of payload", 32'd0, 32'(payloadSeen));
		end
		if (outPayload) begin
			checkCount++;
			assert (payloadSeen < expPayload.size()) else begin
				errorCount++;
				$display("test %s sent more payload bytes than the frame holds", testName);
			end
			if (payloadSeen < expPayload.size()) begin
				checkValue("payload byte", 32'(expPayload[payloadSeen]), 32'(outData));
			end
			payloadSeen++;
			checkValue("headerMatch", matchMask, 32'(headerMatch));
		end
		checkValue("outMatch", payloadDue ? matchMask : 32'd0, 32'(outMatch));
	endtask

	task automatic sendFrame();
		@(negedge CLOCK);
		samplePorts();
		newPacket  = 1'b1;
		dataValid  = 1'b0;
		payloadDue = 1'b0;
		for (int k = 0; k < frameBytes.size(); k++) begin
			@(negedge CLOCK);
			samplePorts();
			newPacket = 1'b0;
			if (nextRandom() < 8'd64) begin
				dataValid  = 1'b0;   // idle cycle
				payloadDue = 1'b0;
				@(negedge CLOCK);
				samplePorts();
			end
			data       = frameBytes[k];
			dataValid  = 1'b1;
			payloadDue = (k >= frameBytes.size() - expPayload.size());
		end
		@(negedge CLOCK);
		samplePorts();
		dataValid  = 1'b0;
		payloadDue = 1'b0;
		repeat (3) begin
			@(negedge CLOCK);
			samplePorts();
		end
	endtask

	task automatic checkFrame(input row_t r);
		logic isTcp;
		int   s;
		isTcp = (r.etherType == 16'h0800) && (r.protocol == 8'd6);
		s     = r.session;
		checkValue("payload count", 32'(expPayload.size()), 32'(payloadSeen));
		checkValue("outNewPacket count", (expPayload.size() > 0) ? 32'd1 : 32'd0,
			32'(newPacketSeen));
		checkValue("headerMatch after frame", matchMask, 32'(headerMatch));
		if (isTcp) begin
			checkValue("srcIp", r.srcIp, srcIp);
			checkValue("dstIp", r.dstIp, dstIp);
			checkValue("srcPort", 32'(r.srcPort), 32'(srcPort));
			checkValue("dstPort", 32'(r.dstPort), 32'(dstPort));
		end
		if (isTcp && s >= 0) begin
			if (r.syn) begin
				modelSeq[s] = r.seq + 32'd1;
				modelGap[s] = 1'b0;
			end else begin
				modelGap[s] = (r.seq != modelSeq[s]);
				modelSeq[s] = r.seq;
			end
			modelSeq[s] = modelSeq[s] + 32'(r.payloadLen);   // one per payload byte
			checkValue("gapped of session", 32'(r.gapped), 32'(gapped[s]));
		end
		checkValue("gapped vector", 32'(modelGap), 32'(gapped));
	endtask

	////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////

	initial begin
		int totalBytes;
		reset          = 1'b1;
		newPacket      = 1'b0;
		dataValid      = 1'b0;
		data           = 8'h00;
		errorCount     = 0;
		checkCount     = 0;
		watchdogCycles = 0;
		payloadDue     = 1'b0;
		matchMask      = 32'd0;
		modelGap       = '0;
		sessionSrcIp   = {32'h0a000003, 32'hac100001, 32'hc0a80105, 32'h0a000001};
		sessionDstIp   = {32'h0a000004, 32'hac100002, 32'hc0a80109, 32'h0a000002};
		sessionSrcPort = {16'd1234, 16'd22, 16'd5000, 16'd1000};
		sessionDstPort = {16'd5678, 16'd2222, 16'd443, 16'd80};
		foreach (modelSeq[i]) begin
			modelSeq[i] = 32'd0;
		end
		fillTable();
		totalBytes = 0;
		foreach (rows[i]) begin
			totalBytes += 14 + 4 * rows[i].vlanTags + rows[i].payloadLen +
				4 * (10 + rows[i].ipOptWords + rows[i].tcpOptWords);
		end
		watchdogCycles = 2 * totalBytes + 10 * rows.size() + 50;
		repeat (2) @(negedge CLOCK);
		reset = 1'b0;
		foreach (rows[i]) begin
			testName = names[i];
			buildFrame(rows[i]);
			matchMask     = (rows[i].session >= 0) ? (32'd1 << rows[i].session) : 32'd0;
			payloadSeen   = 0;
			newPacketSeen = 0;
			sendFrame();
			checkFrame(rows[i]);
		end
		$display("checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles) @(posedge CLOCK);
		$display("run did not finish within %0d clock cycles", watchdogCycles);
		$display("checks %0d, errors %0d", checkCount, errorCount);
		$display("TB FAILED");
		$finish;
	end

endmodule
